// File: packet_q.f
src/pktq_buf_pkg.sv
src/pktq_pkg.sv
src/buffer_alloc.sv
src/packet_scatter.sv
src/desc_fifo.sv
src/buffer_ram.sv
src/packet_gather.sv
src/packet_q_core.sv
tb/tb_clk_gen.sv
tb/packet_q_core_asserts.sv
tb/packet_q_core_tb.sv

// File: Bender.yml
package:
  name: packet_q

sources:
  # Packages first, pktq_pkg uses pktq_buf_pkg
  - src/pktq_buf_pkg.sv
  - src/pktq_pkg.sv
  # Pipeline stages
  - src/buffer_alloc.sv
  - src/packet_scatter.sv
  - src/desc_fifo.sv
  - src/buffer_ram.sv
  - src/packet_gather.sv
  # Top level
  - src/packet_q_core.sv

  # Testbench, top module packet_q_core_tb
  - target: any(test, simulation)
    files:
      - tb/tb_clk_gen.sv
      - tb/packet_q_core_asserts.sv
      - tb/packet_q_core_tb.sv

// File: tb/packet_q_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module packet_q_core_tb import pktq_pkg::*; ();

    localparam int NUM_BUFFERS   = 4;
    localparam int BUFFER_WORDS  = 16;
    localparam int MIN_PKT_WORDS = 2;
    localparam bit DROP_ERRORED  = 1'b1;
    localparam logic [31:0] SEED = 32'h1dd7;

    // Worst case word count of all tests
    localparam int N_RANDOM        = 12;
    localparam int N_STALLED       = 12;
    localparam int TEST_WORDS      = (N_RANDOM + N_STALLED + 5) * 16 + 19 + 36;
    localparam int WATCHDOG_CYCLES = TEST_WORDS * 40 + 2000;

    localparam int RDY_HIGH   = 0;
    localparam int RDY_RANDOM = 1;
    localparam int RDY_LOW    = 2;

    wire         clk;
    wire         rst_n;
    pkt_beat_t   in_beat;
    logic        in_valid;
    logic        in_rdy;
    pkt_beat_t   out_beat;
    logic        out_valid;
    logic        out_rdy;
    logic        init_done;

    logic [31:0] stim_state;
    logic [31:0] rdy_state;
    int          rdy_mode;
    int          errors;
    string       test_name;
    pkt_beat_t   exp_q [$];

    tb_clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(3)) i_clk_gen (.clk, .rst_n);

    packet_q_core #(
        .NUM_BUFFERS   (NUM_BUFFERS),
        .BUFFER_WORDS  (BUFFER_WORDS),
        .MIN_PKT_WORDS (MIN_PKT_WORDS),
        .DROP_ERRORED  (DROP_ERRORED)
    ) UUT (
        .clk, .rst_n, .in_beat, .in_valid, .out_rdy,
        .in_rdy, .out_beat, .out_valid, .init_done
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_stim();
        stim_state = xorshift32(stim_state);
        return stim_state;
    endfunction

    // ------------------------------
    // Input side
    // ------------------------------
    task automatic send_packet(input int len, input bit err);
        meta_t     meta;
        pkt_beat_t beat;
        bit        keep;
        meta = meta_t'(next_stim());
        keep = !(DROP_ERRORED && err) && (len >= MIN_PKT_WORDS) && (len <= BUFFER_WORDS);
        for (int i = 0; i < len; i++) begin
            beat.data = next_stim();
            beat.meta = meta;
            beat.eop  = (i == len - 1);
            beat.err  = err && beat.eop;
            if (keep) begin
                exp_q.push_back('{data: beat.data, meta: meta, eop: beat.eop, err: 1'b0});
            end
            in_beat  = beat;
            in_valid = 1'b1;
            while (!in_rdy) @(negedge clk);
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    task automatic random_packets(input int count);
        for (int i = 0; i < count; i++) begin
            send_packet(2 + int'(next_stim() % 15), 1'b0);
            repeat (next_stim() % 3) @(negedge clk);
        end
    endtask

    task automatic wait_init();
        int cycles;
        cycles = 0;
        while (!init_done && cycles < 50) begin
            assert (!in_rdy) else begin
                errors++;
                $display("Test %s: in_rdy high before init_done", test_name);
            end
            @(negedge clk);
            cycles++;
        end
        if (!init_done) begin
            errors++;
            $display("Test %s: init_done did not rise within 50 cycles", test_name);
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 4000) begin
            @(negedge clk);
            cycles++;
        end
        repeat (20) @(negedge clk);
        if (exp_q.size() != 0) begin
            errors++;
            $display("Test %s: %0d expected words never came out", test_name, exp_q.size());
        end
    endtask

    // ------------------------------
    // Output side
    // ------------------------------
    task automatic check_word();
        pkt_beat_t exp;
        if (exp_q.size() == 0) begin
            errors++;
            $display("Test %s: word %h came out with no packet pending",
                     test_name, out_beat.data);
        end else begin
            exp = exp_q.pop_front();
            assert (out_beat == exp) else begin
                errors++;
                $display("[FAIL] %s: expected data %h meta %h eop %b, actual data %h meta %h eop %b",
                         test_name, exp.data, exp.meta, exp.eop,
                         out_beat.data, out_beat.meta, out_beat.eop);
            end
        end
    endtask

    // Sink sets out_rdy and takes the word in the same falling edge
    initial begin
        out_rdy = 1'b0;
        forever begin
            @(negedge clk);
            case (rdy_mode)
                RDY_HIGH: out_rdy = 1'b1;
                RDY_LOW:  out_rdy = 1'b0;
                default: begin
                    rdy_state = xorshift32(rdy_state);
                    out_rdy   = rdy_state[0] | rdy_state[3];
                end
            endcase
            if (out_valid && out_rdy) begin
                check_word();
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, test_name);
        $display("Check errors: %0d, assertion errors: %0d", errors, UUT.u_asserts.fail_count);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        in_beat    = '0;
        in_valid   = 1'b0;
        errors     = 0;
        rdy_mode   = RDY_HIGH;
        stim_state = SEED;
        rdy_state  = xorshift32(SEED);
        test_name  = "reset";
        @(posedge rst_n);
        @(negedge clk);
        assert (!out_valid && !in_rdy) else begin
            errors++;
            $display("Test %s: out_valid or in_rdy high right after reset", test_name);
        end
        wait_init();

        test_name = "random_lengths";
        random_packets(N_RANDOM);
        wait_drain();

        // Kept, errored, kept, too short, kept
        test_name = "drop_err_short";
        send_packet(4, 1'b0);
        send_packet(5, 1'b1);
        send_packet(3, 1'b0);
        send_packet(1, 1'b0);
        send_packet(6, 1'b0);
        wait_drain();

        test_name = "drop_oversize";
        send_packet(20, 1'b0);
        send_packet(16, 1'b0);
        wait_drain();

        test_name = "random_stall";
        rdy_mode  = RDY_RANDOM;
        random_packets(N_STALLED);
        wait_drain();

        // Packets of 3 words or more keep every buffer busy
        test_name = "full_backpressure";
        rdy_mode  = RDY_LOW;
        repeat (4) send_packet(3 + int'(next_stim() % 14), 1'b0);
        fork
            send_packet(3 + int'(next_stim() % 14), 1'b0);
            begin
                repeat (10) begin
                    assert (!in_rdy) else begin
                        errors++;
                        $display("Test %s: in_rdy high with all buffers in use", test_name);
                    end
                    @(negedge clk);
                end
                rdy_mode = RDY_HIGH;
            end
        join
        wait_drain();

        $display("Check errors: %0d, assertion errors: %0d", errors, UUT.u_asserts.fail_count);
        if (errors == 0 && UUT.u_asserts.fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/packet_q_core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module packet_q_core_asserts import pktq_pkg::*; (
    input wire            clk,
    input wire            rst_n,
    input wire            in_rdy,
    input wire            init_done,
    input wire            out_valid,
    input wire            out_rdy,
    input wire pkt_beat_t out_beat
);

    // Number of assertion failures so far
    int unsigned fail_count = 0;

    // No input accepted while the free list fills
    a_rdy_before_init: assert property (@(posedge clk) disable iff (!rst_n)
        !init_done |-> !in_rdy)
    else begin
        $error("in_rdy high while init_done is low");
        fail_count++;
    end

    // Output stream holds while the sink stalls
    a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_rdy) |=> (out_valid && $stable(out_beat)))
    else begin
        $error("out_beat or out_valid changed under back-pressure");
        fail_count++;
    end

    a_no_err_out: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !out_beat.err)
    else begin
        $error("out_beat.err is set");
        fail_count++;
    end

endmodule

bind packet_q_core packet_q_core_asserts u_asserts (
    .clk, .rst_n, .in_rdy, .init_done, .out_valid, .out_rdy, .out_beat
);

`default_nettype wire

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: src/packet_q_core.sv
`timescale 1ns/1ps
`default_nettype none

module packet_q_core import pktq_pkg::*, pktq_buf_pkg::*; #(
    parameter int NUM_BUFFERS   = 16,
    parameter int BUFFER_WORDS  = 64,
    parameter int MIN_PKT_WORDS = 1,
    parameter bit DROP_ERRORED  = 1'b1
) (
    input  wire            clk,
    input  wire            rst_n,
    input  wire pkt_beat_t in_beat,
    input  wire            in_valid,
    input  wire            out_rdy,
    output logic           in_rdy,
    output pkt_beat_t      out_beat,
    output logic           out_valid,
    output logic           init_done
);

    // ------------------------------
    // Stage wires
    // ------------------------------
    logic      avail;
    buf_ptr_t  head_ptr;
    logic      alloc_take;
    logic      free_valid;
    buf_ptr_t  free_ptr;
    mem_wr_t   mem_wr;
    logic      desc_push;
    pkt_desc_t desc_in;
    logic      desc_pop;
    logic      desc_valid;
    pkt_desc_t desc_out;
    logic      rd_en;
    buf_addr_t rd_addr;
    data_t     rd_data;

    buffer_alloc #(
        .NUM_BUFFERS (NUM_BUFFERS)
    ) i_buffer_alloc (
        .clk, .rst_n, .alloc_take, .free_valid, .free_ptr,
        .avail, .head_ptr, .init_done
    );

    packet_scatter #(
        .BUFFER_WORDS  (BUFFER_WORDS),
        .MIN_PKT_WORDS (MIN_PKT_WORDS),
        .DROP_ERRORED  (DROP_ERRORED)
    ) i_packet_scatter (
        .clk, .rst_n, .in_beat, .in_valid, .avail, .head_ptr, .init_done,
        .in_rdy, .alloc_take, .mem_wr, .desc_push, .desc_in
    );

    desc_fifo #(
        .NUM_BUFFERS (NUM_BUFFERS)
    ) i_desc_fifo (
        .clk, .rst_n, .desc_push, .desc_in, .desc_pop, .desc_valid, .desc_out
    );

    buffer_ram #(
        .NUM_BUFFERS  (NUM_BUFFERS),
        .BUFFER_WORDS (BUFFER_WORDS)
    ) i_buffer_ram (
        .clk, .mem_wr, .rd_en, .rd_addr, .rd_data
    );

    packet_gather i_packet_gather (
        .clk, .rst_n, .desc_valid, .desc_out, .rd_data, .out_rdy,
        .desc_pop, .rd_en, .rd_addr, .free_valid, .free_ptr, .out_beat, .out_valid
    );

endmodule

`default_nettype wire

// File: src/packet_gather.sv
`timescale 1ns/1ps
`default_nettype none

module packet_gather import pktq_pkg::*, pktq_buf_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            desc_valid,
    input  wire pkt_desc_t desc_out,
    input  wire data_t     rd_data,
    input  wire            out_rdy,
    output logic           desc_pop,
    output logic           rd_en,
    output buf_addr_t      rd_addr,
    output logic           free_valid,
    output buf_ptr_t       free_ptr,
    output pkt_beat_t      out_beat,
    output logic           out_valid
);

    typedef enum logic {
        ST_IDLE,
        ST_READ
    } state_t;

    state_t     state;
    pkt_desc_t  cur_desc;
    pkt_len_t   rd_off;
    logic       rd_last;
    logic       rd_pending;
    logic       rd_pend_last;
    pkt_beat_t  ret_beat;
    pkt_beat_t  skid [2];
    logic [1:0] sk_cnt;
    logic [2:0] occ;
    logic       out_fire;
    logic       wr_slot;

    // ------------------------------
    // Read issue
    // ------------------------------
    assign out_fire = out_valid && out_rdy;
    // Entries held plus the read still on its way back
    assign occ      = {1'b0, sk_cnt} + {2'b00, rd_pending};
    assign rd_last  = (rd_off == cur_desc.len - 1'b1);
    assign desc_pop = (state == ST_IDLE) && desc_valid;
    assign rd_en    = (state == ST_READ) && ((occ < 3'd2) || out_fire);
    assign rd_addr  = '{ptr: cur_desc.buf_ptr, offset: buf_offset_t'(rd_off)};

    // Buffer goes back as soon as its last word has been read
    assign free_valid = rd_en && rd_last;
    assign free_ptr   = cur_desc.buf_ptr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            rd_pending <= 1'b0;
            sk_cnt     <= '0;
        end else begin
            rd_pending <= rd_en;
            sk_cnt     <= sk_cnt + 2'(rd_pending) - 2'(out_fire);
            case (state)
                ST_IDLE: begin
                    if (desc_valid) begin
                        state <= ST_READ;
                    end
                end
                ST_READ: begin
                    if (rd_en && rd_last) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ------------------------------
    // Skid buffer
    // ------------------------------
    assign ret_beat = '{data: rd_data, meta: cur_desc.meta, eop: rd_pend_last, err: 1'b0};
    assign wr_slot  = out_fire ? (sk_cnt == 2'd2) : (sk_cnt == 2'd1);

    always_ff @(posedge clk) begin
        if (desc_pop) begin
            cur_desc <= desc_out;
            rd_off   <= '0;
        end else if (rd_en) begin
            rd_off <= rd_off + 1'b1;
        end
        if (rd_en) begin
            rd_pend_last <= rd_last;
        end
        if (out_fire) begin
            skid[0] <= skid[1];
        end
        // Overrides the shift when the new word lands in slot 0
        if (rd_pending) begin
            skid[wr_slot] <= ret_beat;
        end
    end

    assign out_valid = (sk_cnt != '0);
    assign out_beat  = skid[0];

endmodule

`default_nettype wire

// File: src/buffer_ram.sv
`timescale 1ns/1ps
`default_nettype none

module buffer_ram import pktq_pkg::*, pktq_buf_pkg::*; #(
    parameter int NUM_BUFFERS  = 16,
    parameter int BUFFER_WORDS = 64
) (
    input  wire            clk,
    input  wire mem_wr_t   mem_wr,
    input  wire            rd_en,
    input  wire buf_addr_t rd_addr,
    output data_t          rd_data
);

    data_t mem [NUM_BUFFERS * BUFFER_WORDS];

    // Buffers sit back to back in the array
    function automatic int word_index(input buf_addr_t addr);
        return int'(addr.ptr) * BUFFER_WORDS + int'(addr.offset);
    endfunction

    always_ff @(posedge clk) begin
        if (mem_wr.wr_en) begin
            mem[word_index(mem_wr.addr)] <= mem_wr.data;
        end
        if (rd_en) begin
            rd_data <= mem[word_index(rd_addr)];
        end
    end

endmodule

`default_nettype wire

// File: src/desc_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module desc_fifo import pktq_pkg::*; #(
    parameter int NUM_BUFFERS = 16
) (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            desc_push,
    input  wire pkt_desc_t desc_in,
    input  wire            desc_pop,
    output logic           desc_valid,
    output pkt_desc_t      desc_out
);

    localparam int IDX_W = (NUM_BUFFERS > 1) ? $clog2(NUM_BUFFERS) : 1;

    pkt_desc_t        entries [NUM_BUFFERS];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W:0]   count;
    logic             pop;

    function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
        return (idx == IDX_W'(NUM_BUFFERS - 1)) ? '0 : idx + 1'b1;
    endfunction

    // Head entry shows as soon as it is written
    assign desc_valid = (count != '0);
    assign desc_out   = entries[rd_idx];
    assign pop        = desc_pop && desc_valid;

    always_ff @(posedge clk) begin
        if (desc_push) begin
            entries[wr_idx] <= desc_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_idx <= '0;
            wr_idx <= '0;
            count  <= '0;
        end else begin
            if (desc_push) begin
                wr_idx <= next_idx(wr_idx);
            end
            if (pop) begin
                rd_idx <= next_idx(rd_idx);
            end
            if (desc_push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !desc_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/packet_scatter.sv
`timescale 1ns/1ps
`default_nettype none

module packet_scatter import pktq_pkg::*, pktq_buf_pkg::*; #(
    parameter int BUFFER_WORDS  = 64,
    parameter int MIN_PKT_WORDS = 1,
    parameter bit DROP_ERRORED  = 1'b1
) (
    input  wire            clk,
    input  wire            rst_n,
    input  wire pkt_beat_t in_beat,
    input  wire            in_valid,
    input  wire            avail,
    input  wire buf_ptr_t  head_ptr,
    input  wire            init_done,
    output logic           in_rdy,
    output logic           alloc_take,
    output mem_wr_t        mem_wr,
    output logic           desc_push,
    output pkt_desc_t      desc_in
);

    logic     have_buf;
    buf_ptr_t cur_ptr;
    buf_ptr_t wr_ptr;
    pkt_len_t word_cnt;
    pkt_len_t pkt_len;
    // Buffer is full, later words of this packet are discarded
    logic     ovf;
    logic     beat_fire;
    logic     eop_fire;
    logic     drop;

    // Without a held buffer the head of the free list is used directly
    assign wr_ptr     = have_buf ? cur_ptr : head_ptr;
    assign alloc_take = !have_buf && avail;
    assign in_rdy     = init_done && (have_buf || avail);
    assign beat_fire  = in_valid && in_rdy;
    assign eop_fire   = beat_fire && in_beat.eop;
    assign pkt_len    = word_cnt + 1'b1;

    // ------------------------------
    // Keep or drop at eop
    // ------------------------------
    assign drop = (DROP_ERRORED && in_beat.err)
               || (int'(pkt_len) < MIN_PKT_WORDS)
               || ovf;

    always_comb begin
        mem_wr.wr_en       = beat_fire && !ovf;
        mem_wr.addr.ptr    = wr_ptr;
        mem_wr.addr.offset = buf_offset_t'(word_cnt);
        mem_wr.data        = in_beat.data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            have_buf  <= 1'b0;
            word_cnt  <= '0;
            ovf       <= 1'b0;
            desc_push <= 1'b0;
        end else begin
            desc_push <= 1'b0;
            if (alloc_take) begin
                have_buf <= 1'b1;
            end
            if (eop_fire) begin
                word_cnt <= '0;
                ovf      <= 1'b0;
                // A dropped packet leaves its buffer for the next one
                if (!drop) begin
                    have_buf  <= 1'b0;
                    desc_push <= 1'b1;
                end
            end else if (beat_fire && !ovf) begin
                word_cnt <= pkt_len;
                if (word_cnt == pkt_len_t'(BUFFER_WORDS - 1)) begin
                    ovf <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_take) begin
            cur_ptr <= head_ptr;
        end
        if (eop_fire) begin
            desc_in.buf_ptr <= wr_ptr;
            desc_in.len     <= pkt_len;
            desc_in.meta    <= in_beat.meta;
        end
    end

endmodule

`default_nettype wire

// File: src/buffer_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module buffer_alloc import pktq_buf_pkg::*; #(
    parameter int NUM_BUFFERS = 16
) (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           alloc_take,
    input  wire           free_valid,
    input  wire buf_ptr_t free_ptr,
    output logic          avail,
    output buf_ptr_t      head_ptr,
    output logic          init_done
);

    localparam int IDX_W = (NUM_BUFFERS > 1) ? $clog2(NUM_BUFFERS) : 1;

    buf_ptr_t         fl_mem [NUM_BUFFERS];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W:0]   count;
    logic             filling;
    buf_ptr_t         fill_ptr;
    logic             push;
    buf_ptr_t         push_ptr;
    logic             pop;

    function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
        return (idx == IDX_W'(NUM_BUFFERS - 1)) ? '0 : idx + 1'b1;
    endfunction

    // Fill sequencer owns the push port until every pointer is in
    assign push     = filling || free_valid;
    assign push_ptr = filling ? fill_ptr : free_ptr;
    assign pop      = alloc_take && avail;

    assign avail    = init_done && (count != '0);
    assign head_ptr = fl_mem[rd_idx];

    always_ff @(posedge clk) begin
        if (push) begin
            fl_mem[wr_idx] <= push_ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_idx    <= '0;
            wr_idx    <= '0;
            count     <= '0;
            filling   <= 1'b1;
            fill_ptr  <= '0;
            init_done <= 1'b0;
        end else begin
            if (push) begin
                wr_idx <= next_idx(wr_idx);
            end
            if (pop) begin
                rd_idx <= next_idx(rd_idx);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
            // One pointer per cycle, done after the last one
            if (filling) begin
                fill_ptr <= fill_ptr + 1'b1;
                if (fill_ptr == buf_ptr_t'(NUM_BUFFERS - 1)) begin
                    filling   <= 1'b0;
                    init_done <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/pktq_pkg.sv
`default_nettype none

package pktq_pkg;

    // ------------------------------
    // Stream widths
    // ------------------------------
    localparam int DATA_WIDTH = pktq_buf_pkg::WORD_WIDTH;
    localparam int META_WIDTH = 8;

    // Up to 64 words in a packet
    localparam int LEN_WIDTH  = 7;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [META_WIDTH-1:0] meta_t;
    typedef logic [LEN_WIDTH-1:0]  pkt_len_t;

    // ------------------------------
    // Stream beat
    // ------------------------------
    typedef struct packed {
        data_t data;
        meta_t meta;
        logic  eop;
        // Only meaningful together with eop
        logic  err;
    } pkt_beat_t;

    // ------------------------------
    // Completed packet descriptor
    // ------------------------------
    typedef struct packed {
        pktq_buf_pkg::buf_ptr_t buf_ptr;
        pkt_len_t               len;
        meta_t                  meta;
    } pkt_desc_t;

endpackage

`default_nettype wire

// File: src/pktq_buf_pkg.sv
`default_nettype none

package pktq_buf_pkg;

    // ------------------------------
    // Buffer memory geometry
    // ------------------------------
    localparam int PTR_WIDTH    = 4;
    localparam int OFFSET_WIDTH = 6;

    // RAM word, same as the stream data word
    localparam int WORD_WIDTH   = 32;

    typedef logic [PTR_WIDTH-1:0]    buf_ptr_t;
    typedef logic [OFFSET_WIDTH-1:0] buf_offset_t;

    // Word address, buffer number in the upper bits
    typedef struct packed {
        buf_ptr_t    ptr;
        buf_offset_t offset;
    } buf_addr_t;

    typedef struct packed {
        logic                  wr_en;
        buf_addr_t             addr;
        logic [WORD_WIDTH-1:0] data;
    } mem_wr_t;

endpackage

`default_nettype wire
